// ==== common/dot_cfg.svh ====
// Build-time sizing for the dot-product pipeline
// Include wherever the operand width or lane count is needed
// Edit the values here to resize every stage at once

`ifndef DOT_CFG_SVH
`define DOT_CFG_SVH

// ====================
// Datapath sizing
// ====================

// Bit width of every operand, product, partial sum and result
// Arithmetic wraps at this width in every stage
`define DOT_WIDTH 16

// Operands per input vector
// Must be a power of two and at least 2
// Operands are multiplied in adjacent pairs, so 8 lanes give 4 products
`define DOT_LANES 8

`endif

// ==== common/dot_pkg.sv ====
// Shared types and derived sizes for the dot-product pipeline
// Each module imports this package inside its body
// Raw sizing comes from the cfg header

`include "dot_cfg.svh"

package dot_pkg;

   // ====================
   // Scalar types
   // ====================

   // One operand, product or partial sum
   // Always unsigned, always DOT_WIDTH bits wide
   typedef logic [`DOT_WIDTH-1:0] dot_data_t;

   // ====================
   // Derived sizes
   // ====================

   // Number of products formed from one vector
   localparam int DOT_PAIRS = `DOT_LANES / 2;

   // Register levels in the adder tree
   // Zero when there is only one product to pass through
   localparam int DOT_ADD_LEVELS = $clog2(DOT_PAIRS);

   // Edge-to-edge latency from input to result
   // Input register and product register, then one per tree level
   localparam int DOT_LATENCY = 2 + DOT_ADD_LEVELS;

   // ====================
   // Stage payloads
   // ====================

   // Input vector with its valid flag
   // data[i] is operand i, paired as (0,1), (2,3) and so on
   typedef struct packed {
      logic                          valid;
      dot_data_t [`DOT_LANES-1:0]    data;
   } dot_vec_t;

   // Truncated pairwise products with the matching valid flag
   // data[i] holds operand 2i times operand 2i+1
   typedef struct packed {
      logic                          valid;
      dot_data_t [DOT_PAIRS-1:0]     data;
   } dot_prod_t;

endpackage

// ==== dot_pipe.f ====
+incdir+common
common/dot_pkg.sv
hw/dot_pipe/dot_mult_stage.sv
hw/dot_pipe/dot_add_tree.sv
hw/dot_pipe_top.sv
test/tb_clock.sv
test/dot_pipe_tb.sv

// ==== hw/dot_pipe/dot_add_tree.sv ====
// Registered binary adder tree for the dot-product pipeline
// Reduces DOT_PAIRS products to one sum, one register level per halving
// Each level carries its own valid so several vectors can be in flight

module dot_add_tree (
   input  logic               clk,
   input  logic               rst,
   input  dot_pkg::dot_prod_t prod,
   output dot_pkg::dot_data_t sum,
   output logic               sum_valid
);

   import dot_pkg::*;

   genvar lvl;

   generate
      if (DOT_ADD_LEVELS == 0) begin : g_bypass

         // ====================
         // Single product
         // ====================

         // Two lanes give one product, nothing left to add
         // The product register upstream already sets the latency
         assign sum       = prod.data[0];
         assign sum_valid = prod.valid;

      end else begin : g_tree

         // ====================
         // Tree levels
         // ====================

         // Level 0 sits on the products, the last level holds one sum
         for (lvl = 0; lvl < DOT_ADD_LEVELS; lvl++) begin : g_lvl

            // Partial sums feeding this level and produced by it
            localparam int IN_N  = DOT_PAIRS >> lvl;
            localparam int OUT_N = IN_N / 2;

            // Inputs to this level
            dot_data_t [IN_N-1:0]  part_in;
            logic                  lvl_valid_in;

            // Registered outputs of this level
            dot_data_t [OUT_N-1:0] part_r;
            logic                  valid_r;

            // Select the source of this level
            if (lvl == 0) begin : g_src
               // First level reads the product register
               assign part_in      = prod.data;
               assign lvl_valid_in = prod.valid;
            end else begin : g_src
               // Later levels read the level below
               assign part_in      = g_lvl[lvl-1].part_r;
               assign lvl_valid_in = g_lvl[lvl-1].valid_r;
            end

            // Adjacent pairs added, carry out of the top bit discarded
            always_ff @(posedge clk or posedge rst) begin
               if (rst) begin
                  part_r  <= '0;
                  valid_r <= 1'b0;
               end else begin
                  for (int i = 0; i < OUT_N; i++) begin
                     part_r[i] <= part_in[2*i] + part_in[2*i+1];
                  end
                  // Valid steps forward one level per cycle
                  valid_r <= lvl_valid_in;
               end
            end

         end

         // ====================
         // Result
         // ====================

         // Last level has exactly one partial sum left
         assign sum       = g_lvl[DOT_ADD_LEVELS-1].part_r[0];
         assign sum_valid = g_lvl[DOT_ADD_LEVELS-1].valid_r;

      end
   endgenerate

endmodule

// ==== hw/dot_pipe/dot_mult_stage.sv ====
// Front two stages of the dot-product pipeline
// Registers the incoming vector, then registers the pairwise products
// Valid moves through both registers together with the data

module dot_mult_stage (
   input  logic              clk,
   input  logic              rst,
   input  dot_pkg::dot_vec_t vec,
   output dot_pkg::dot_prod_t prod
);

   import dot_pkg::*;

   // ====================
   // Stage 1 input register
   // ====================

   // Captured vector, loaded every cycle whatever the valid flag
   dot_vec_t vec_r;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vec_r <= '0;
      end else begin
         // Data is taken blindly, valid tells the later stages if it matters
         vec_r <= vec;
      end
   end

   // ====================
   // Pairwise multiply
   // ====================

   // Unregistered products of the captured operands
   dot_data_t [DOT_PAIRS-1:0] prod_next;

   always_comb begin
      for (int i = 0; i < DOT_PAIRS; i++) begin
         // Even operand times odd neighbour
         // Upper half of the full product is dropped by the assignment width
         prod_next[i] = vec_r.data[2*i] * vec_r.data[2*i+1];
      end
   end

   // ====================
   // Stage 2 product register
   // ====================

   dot_prod_t prod_r;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         prod_r <= '0;
      end else begin
         // Valid follows the operands it belongs to
         prod_r.valid <= vec_r.valid;
         prod_r.data  <= prod_next;
      end
   end

   // Products leave straight from the register
   assign prod = prod_r;

endmodule

// ==== hw/dot_pipe_top.sv ====
// Top level of the pipelined dot-product engine
// Takes one vector per cycle with a valid flag and no back-pressure
// Result appears DOT_LATENCY cycles later with valid_out high

`include "dot_cfg.svh"

module dot_pipe_top (
   input  logic                                clk,
   input  logic                                rst,
   input  dot_pkg::dot_data_t [`DOT_LANES-1:0] operands,
   input  logic                                valid_in,
   output dot_pkg::dot_data_t                  out,
   output logic                                valid_out
);

   import dot_pkg::*;

   // ====================
   // Input packing
   // ====================

   // Operands and valid bundled for the multiply stage
   dot_vec_t  vec_in;

   // Products handed from the multiply stage to the tree
   dot_prod_t prod;

   assign vec_in.valid = valid_in;
   assign vec_in.data  = operands;

   // ====================
   // Stage chain
   // ====================

   // Input register and pairwise multiply, two cycles
   dot_mult_stage u_mult (
      .clk  (clk),
      .rst  (rst),
      .vec  (vec_in),
      .prod (prod)
   );

   // Adder tree, DOT_ADD_LEVELS cycles
   // Its last level drives the engine outputs directly
   dot_add_tree u_tree (
      .clk       (clk),
      .rst       (rst),
      .prod      (prod),
      .sum       (out),
      .sum_valid (valid_out)
   );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the dot-product testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot enter the project directory"
   exit 1
fi

verilator --binary --timing --assert \
   --top-module dot_pipe_tb \
   --Mdir obj_dir -o dot_pipe_sim \
   -f dot_pipe.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_output="$(./obj_dir/dot_pipe_sim 2>&1)"
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -qx "Simulation finished: PASS"; then
   exit 0
else
   echo "Pass line not found in the simulation output"
   exit 1
fi

// ==== test/dot_pipe_tb.sv ====
// Self-checking testbench for the pipelined dot-product engine
// Random vectors plus forced runs, checked against a queue-based reference model
// Checks run on the falling edge where every DUT output is settled

`include "dot_cfg.svh"

module dot_pipe_tb;

   import dot_pkg::*;

   typedef dot_data_t [`DOT_LANES-1:0] lanes_t;
   typedef logic [2*`DOT_WIDTH-1:0]    wide_t;

   localparam int TOTAL_VECTORS = 2000;
   localparam int RESET_WAIT    = 50;
   localparam int DRAIN_LIMIT   = 100;

   logic      clk;
   logic      rst;
   lanes_t    operands;
   logic      valid_in;
   dot_data_t out;
   logic      valid_out;

   // Generator state and progress counter
   logic [31:0] rng;
   int          sent     = 0;

   // Expected results in issue order, with a flag for all-max vectors
   dot_data_t exp_q[$];
   bit        max_q[$];

   tb_clock u_clock (
      .clk (clk),
      .rst (rst)
   );

   dot_pipe_top uut (
      .clk       (clk),
      .rst       (rst),
      .operands  (operands),
      .valid_in  (valid_in),
      .out       (out),
      .valid_out (valid_out)
   );

   // ====================
   // Helpers
   // ====================

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic value_error(input string msg);
      $display("Fail at time %0t: %s", $time, msg);
      abort_run();
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Sum of adjacent-pair products, each wrapped to the data width
   function automatic dot_data_t dot_model(input lanes_t v);
      wide_t     full;
      dot_data_t acc;
      acc = '0;
      for (int i = 0; i < `DOT_LANES / 2; i++) begin
         full = wide_t'(v[2*i]) * wide_t'(v[2*i+1]);
         acc  = acc + full[`DOT_WIDTH-1:0];
      end
      return acc;
   endfunction

   task automatic random_lanes(output lanes_t data);
      for (int i = 0; i < `DOT_LANES; i++) begin
         rng     = xorshift32(rng);
         data[i] = dot_data_t'(rng);
      end
   endtask

   // One rising edge, inputs updated after the DUT has sampled
   task automatic send_cycle(input logic valid, input lanes_t data);
      @(posedge clk);
      operands <= data;
      valid_in <= valid;
      if (valid) sent++;
   endtask

   // Valid about 70 percent of the time
   task automatic random_cycle();
      lanes_t data;
      logic   valid;
      rng   = xorshift32(rng);
      valid = (rng % 32'd10) < 32'd7;
      random_lanes(data);
      send_cycle(valid, data);
   endtask

   // Each lane is either all ones or zero
   task automatic mixed_cycle();
      lanes_t data;
      for (int i = 0; i < `DOT_LANES; i++) begin
         rng     = xorshift32(rng);
         data[i] = {`DOT_WIDTH{rng[3]}};
      end
      send_cycle(1'b1, data);
   endtask

   // ====================
   // Stimulus
   // ====================

   initial begin
      int guard;
      rng = 32'd86870;
      // Nonzero operands under reset, data registers must still read zero
      operands <= '1;
      valid_in <= 1'b0;
      guard = 0;
      @(posedge clk);
      while (rst === 1'b1 && guard < RESET_WAIT) begin
         @(posedge clk);
         guard++;
      end
      if (rst !== 1'b0) begin
         $display("Reset was never released");
         abort_run();
      end
      while (sent < 400) random_cycle();
      // Unbroken run, fills the whole pipeline
      repeat (32) begin
         lanes_t data;
         random_lanes(data);
         send_cycle(1'b1, data);
      end
      repeat (8) send_cycle(1'b1, '1);
      repeat (8) mixed_cycle();
      while (sent < TOTAL_VECTORS) random_cycle();
      send_cycle(1'b0, '0);
      // Drain
      guard = 0;
      while (exp_q.size() != 0 && guard < DRAIN_LIMIT) begin
         @(posedge clk);
         guard++;
      end
      if (exp_q.size() != 0) begin
         $display("Results stopped arriving with %0d still outstanding", exp_q.size());
         abort_run();
      end
      // Quiet tail, any late extra result trips the checker
      repeat (DOT_LATENCY + 4) send_cycle(1'b0, '0);
      $display("Simulation finished: PASS");
      $finish;
   end

   // ====================
   // Checker
   // ====================

   initial begin
      logic [DOT_LATENCY-1:0] hist;
      int                     after_rst;
      dot_data_t              expected;
      bit                     is_max;
      hist      = '0;
      after_rst = 0;
      @(posedge clk);
      forever begin
         @(negedge clk);
         if (rst) begin
            assert (valid_out == 1'b0 && out == '0)
               else value_error("outputs not cleared during reset");
            hist      = '0;
            after_rst = 0;
         end else begin
            // Pipeline still holds reset values
            if (after_rst < DOT_LATENCY) begin
               assert (valid_out == 1'b0 && out == '0)
                  else value_error($sformatf("output active %0d cycles after reset",
                                             after_rst + 1));
               after_rst++;
            end
            // valid_in delayed by the full latency
            assert (valid_out == hist[DOT_LATENCY-1])
               else value_error($sformatf("valid_out %0b, expected %0b",
                                          valid_out, hist[DOT_LATENCY-1]));
            if (valid_out) begin
               assert (exp_q.size() != 0) else value_error("result with no vector outstanding");
               expected = exp_q.pop_front();
               is_max   = max_q.pop_front();
               assert (out == expected)
                  else value_error($sformatf("out %0h, expected %0h", out, expected));
               // Each max product wraps to 1, so the sum is the pair count
               if (is_max) begin
                  assert (out == dot_data_t'(DOT_PAIRS))
                     else value_error($sformatf("all-max out %0h, expected %0h",
                                                out, dot_data_t'(DOT_PAIRS)));
               end
            end
            hist = {hist[DOT_LATENCY-2:0], valid_in};
            if (valid_in) begin
               exp_q.push_back(dot_model(operands));
               max_q.push_back(operands == '1);
            end
         end
      end
   end

endmodule

// ==== test/tb_clock.sv ====
// Clock and reset source for the dot-product testbench
// clk has a period of 10, rst is held high for the first 8 rising edges

module tb_clock (
   output logic clk,
   output logic rst
);

   // Free-running clock, first rising edge at time 5
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset drops on the 8th rising edge, like any other driven input
   initial begin
      rst <= 1'b1;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
   end

endmodule
